//--- design/rv32_pkg.sv
package rv32_pkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_e;

  // Controller states, one instruction at a time
  typedef enum logic [2:0] {
    CTRL_FETCH      = 3'd0,
    CTRL_WAIT_INSTR = 3'd1,
    CTRL_EXECUTE    = 3'd2,
    CTRL_MEM        = 3'd3,
    CTRL_HALT       = 3'd4
  } ctrl_state_e;

  // Load/store unit states
  typedef enum logic [1:0] {
    LSU_IDLE = 2'd0,
    LSU_REQ  = 2'd1,
    LSU_WAIT = 2'd2
  } lsu_state_e;

  // OBI request and response
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } obi_rsp_t;

  typedef struct packed {
    alu_op_e     alu_op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        use_imm;
    logic        rf_we;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        illegal;
  } decoded_t;

  // One retired instruction
  typedef struct packed {
    logic        valid;
    logic        is_store;
    logic [31:0] pc;
  } retire_t;

endpackage

//--- design/rv32_decoder.sv
`timescale 1ns/1ps

module rv32_decoder (
  input  logic [31:0]        instr_i,
  output rv32_pkg::decoded_t decoded_o
);
  import rv32_pkg::*;

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Immediates per instruction format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};

  always_comb begin
    decoded_o        = '0;
    decoded_o.alu_op = ALU_ADD;
    decoded_o.rs1    = instr_i[19:15];
    decoded_o.rs2    = instr_i[24:20];
    decoded_o.rd     = instr_i[11:7];
    case (opcode)
      OPC_OP: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: decoded_o.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: decoded_o.alu_op = ALU_SUB;
          {7'b0000000, 3'b100}: decoded_o.alu_op = ALU_XOR;
          {7'b0000000, 3'b110}: decoded_o.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: decoded_o.alu_op = ALU_AND;
          default:              decoded_o.illegal = 1'b1;
        endcase
        decoded_o.rf_we = !decoded_o.illegal;
      end
      OPC_OP_IMM: begin
        // ADDI only
        decoded_o.imm     = imm_i;
        decoded_o.use_imm = 1'b1;
        decoded_o.rf_we   = (funct3 == 3'b000);
        decoded_o.illegal = (funct3 != 3'b000);
      end
      OPC_LUI: begin
        decoded_o.alu_op  = ALU_PASS_B;
        decoded_o.imm     = imm_u;
        decoded_o.use_imm = 1'b1;
        decoded_o.rf_we   = 1'b1;
      end
      OPC_LOAD: begin
        decoded_o.imm     = imm_i;
        decoded_o.use_imm = 1'b1;
        decoded_o.rf_we   = (funct3 == 3'b010);
        decoded_o.is_load = (funct3 == 3'b010);
        decoded_o.illegal = (funct3 != 3'b010);
      end
      OPC_STORE: begin
        decoded_o.imm      = imm_s;
        decoded_o.use_imm  = 1'b1;
        decoded_o.is_store = (funct3 == 3'b010);
        decoded_o.illegal  = (funct3 != 3'b010);
      end
      OPC_BRANCH: begin
        // BEQ compares rs1 with rs2, imm is the PC offset
        decoded_o.imm       = imm_b;
        decoded_o.is_branch = (funct3 == 3'b000);
        decoded_o.illegal   = (funct3 != 3'b000);
      end
      default: decoded_o.illegal = 1'b1;
    endcase
  end

endmodule

//--- design/rv32_alu.sv
`timescale 1ns/1ps

module rv32_alu (
  input  rv32_pkg::alu_op_e op_i,
  input  logic [31:0]       a_i,
  input  logic [31:0]       b_i,
  output logic [31:0]       result_o,
  output logic              equal_o
);
  import rv32_pkg::*;

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_OR:     result_o = a_i | b_i;
      ALU_XOR:    result_o = a_i ^ b_i;
      // LUI passes the upper immediate through
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

  // Branch compare
  assign equal_o = (a_i == b_i);

endmodule

//--- design/rv32_register_file.sv
`timescale 1ns/1ps

module rv32_register_file (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i
);

  // x1 to x31, x0 has no storage
  logic [31:0] regs_q [31:1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 : regs_q[raddr_b_i];

endmodule

//--- design/rv32_load_store_unit.sv
`timescale 1ns/1ps

module rv32_load_store_unit (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               start_i,
  input  logic               we_i,
  input  logic [31:0]        addr_i,
  input  logic [31:0]        wdata_i,
  output logic               done_o,
  output logic [31:0]        rdata_o,
  output rv32_pkg::obi_req_t data_req_o,
  input  rv32_pkg::obi_rsp_t data_rsp_i
);
  import rv32_pkg::*;

  lsu_state_e  state_q;
  lsu_state_e  state_d;
  logic        we_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      LSU_IDLE: if (start_i) state_d = LSU_REQ;
      LSU_REQ:  if (data_rsp_i.gnt) state_d = LSU_WAIT;
      LSU_WAIT: if (data_rsp_i.rvalid) state_d = LSU_IDLE;
      default:  state_d = LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LSU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, held until grant
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  // Word accesses only
  assign data_req_o = '{req: (state_q == LSU_REQ), addr: addr_q, we: we_q,
                        be: 4'b1111, wdata: wdata_q};

  assign done_o  = (state_q == LSU_WAIT) && data_rsp_i.rvalid;
  assign rdata_o = data_rsp_i.rdata;

  a_no_start_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> (state_q == LSU_IDLE))
    else $error("LSU started while an access is in flight");

  a_rvalid_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_rsp_i.rvalid |-> (state_q == LSU_WAIT))
    else $error("Data rvalid without an outstanding request");

endmodule

//--- design/rv32_core.sv
`timescale 1ns/1ps

module rv32_core (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               fetch_enable_i,
  input  logic [31:0]        boot_addr_i,
  output rv32_pkg::obi_req_t instr_req_o,
  input  rv32_pkg::obi_rsp_t instr_rsp_i,
  output rv32_pkg::obi_req_t data_req_o,
  input  rv32_pkg::obi_rsp_t data_rsp_i,
  output logic               core_sleep_o,
  output rv32_pkg::retire_t  retire_o
);
  import rv32_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        enabled_q;
  logic [31:0] pc_q;
  logic [31:0] pc_next;
  logic [31:0] ir_q;
  decoded_t    dec;
  logic        mem_op;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        alu_equal;
  logic        lsu_start;
  logic        lsu_done;
  logic [31:0] lsu_rdata;
  logic        rf_we;
  logic [31:0] rf_wdata;
  logic        retire_valid;

  rv32_decoder u_decoder (
    .instr_i   (ir_q),
    .decoded_o (dec)
  );

  assign alu_b  = dec.use_imm ? dec.imm : rs2_data;
  assign mem_op = dec.is_load || dec.is_store;

  rv32_alu u_alu (
    .op_i     (dec.alu_op),
    .a_i      (rs1_data),
    .b_i      (alu_b),
    .result_o (alu_result),
    .equal_o  (alu_equal)
  );

  // Write back ALU results in EXECUTE, load data in MEM
  assign rf_we    = ((state_q == CTRL_EXECUTE) && dec.rf_we && !dec.is_load) ||
                    ((state_q == CTRL_MEM) && lsu_done && dec.is_load);
  assign rf_wdata = (state_q == CTRL_MEM) ? lsu_rdata : alu_result;

  rv32_register_file u_register_file (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .we_i      (rf_we),
    .waddr_i   (dec.rd),
    .wdata_i   (rf_wdata)
  );

  assign lsu_start = (state_q == CTRL_EXECUTE) && mem_op;

  rv32_load_store_unit u_load_store_unit (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (lsu_start),
    .we_i       (dec.is_store),
    .addr_i     (alu_result),
    .wdata_i    (rs2_data),
    .done_o     (lsu_done),
    .rdata_o    (lsu_rdata),
    .data_req_o (data_req_o),
    .data_rsp_i (data_rsp_i)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_FETCH:      if (instr_req_o.req && instr_rsp_i.gnt) state_d = CTRL_WAIT_INSTR;
      CTRL_WAIT_INSTR: if (instr_rsp_i.rvalid) state_d = CTRL_EXECUTE;
      CTRL_EXECUTE: begin
        if (dec.illegal) begin
          state_d = CTRL_HALT;
        end else if (mem_op) begin
          state_d = CTRL_MEM;
        end else begin
          state_d = CTRL_FETCH;
        end
      end
      CTRL_MEM:        if (lsu_done) state_d = CTRL_FETCH;
      default:         state_d = CTRL_HALT;
    endcase
  end

  assign retire_valid = ((state_q == CTRL_EXECUTE) && !dec.illegal && !mem_op) ||
                        ((state_q == CTRL_MEM) && lsu_done);
  assign pc_next = (dec.is_branch && alu_equal) ? pc_q + dec.imm : pc_q + 32'd4;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= CTRL_FETCH;
      enabled_q <= 1'b0;
      pc_q      <= '0;
    end else begin
      state_q <= state_d;
      if (fetch_enable_i) enabled_q <= 1'b1;
      // Track the boot address until fetching starts
      if (!enabled_q) begin
        pc_q <= boot_addr_i;
      end else if (retire_valid) begin
        pc_q <= pc_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == CTRL_WAIT_INSTR) && instr_rsp_i.rvalid) ir_q <= instr_rsp_i.rdata;
  end

  assign instr_req_o = '{req: (state_q == CTRL_FETCH) && enabled_q, addr: pc_q,
                         we: 1'b0, be: 4'b1111, wdata: 32'd0};
  assign core_sleep_o = (state_q == CTRL_HALT);
  assign retire_o     = '{valid: retire_valid, is_store: retire_valid && dec.is_store,
                          pc: pc_q};

  // HALT is final and silences both buses
  a_halt_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == CTRL_HALT) |=> (state_q == CTRL_HALT) && !instr_req_o.req &&
                               !data_req_o.req)
    else $error("Request issued after halt");

  a_instr_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o.req && !instr_rsp_i.gnt |=> instr_req_o.req && $stable(instr_req_o.addr))
    else $error("Instruction request changed before grant");

endmodule

//--- design/rv32_retire_counter.sv
`timescale 1ns/1ps

module rv32_retire_counter (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  rv32_pkg::retire_t retire_i,
  output logic [31:0]       instret_o,
  output logic [31:0]       store_count_o
);
  import rv32_pkg::*;

  // Both counters wrap at 2**32
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instret_o     <= '0;
      store_count_o <= '0;
    end else begin
      if (retire_i.valid) instret_o <= instret_o + 32'd1;
      if (retire_i.valid && retire_i.is_store) begin
        store_count_o <= store_count_o + 32'd1;
      end
    end
  end

  a_store_has_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    retire_i.is_store |-> retire_i.valid)
    else $error("Store retire without valid");

endmodule

//--- design/rv32_core_wrapper.sv
`timescale 1ns/1ps

module rv32_core_wrapper (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        fetch_enable_i,
  input  logic [31:0] boot_addr_i,
  // Instruction bus
  output logic        instr_req_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  output logic [31:0] instr_addr_o,
  input  logic [31:0] instr_rdata_i,
  input  logic        instr_err_i,
  // Data bus
  output logic        data_req_o,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  output logic        data_we_o,
  output logic [3:0]  data_be_o,
  output logic [31:0] data_addr_o,
  output logic [31:0] data_wdata_o,
  input  logic [31:0] data_rdata_i,
  input  logic        data_err_i,
  output logic        core_sleep_o,
  output logic [31:0] instret_o,
  output logic [31:0] store_count_o
);
  import rv32_pkg::*;

  obi_req_t instr_req;
  obi_rsp_t instr_rsp;
  obi_req_t data_req;
  obi_rsp_t data_rsp;
  retire_t  retire;

  assign instr_rsp = '{gnt: instr_gnt_i, rvalid: instr_rvalid_i, rdata: instr_rdata_i,
                       err: instr_err_i};
  assign data_rsp  = '{gnt: data_gnt_i, rvalid: data_rvalid_i, rdata: data_rdata_i,
                       err: data_err_i};

  assign instr_req_o  = instr_req.req;
  assign instr_addr_o = instr_req.addr;
  assign data_req_o   = data_req.req;
  assign data_we_o    = data_req.we;
  assign data_be_o    = data_req.be;
  assign data_addr_o  = data_req.addr;
  assign data_wdata_o = data_req.wdata;

  rv32_core u_core (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req),
    .instr_rsp_i    (instr_rsp),
    .data_req_o     (data_req),
    .data_rsp_i     (data_rsp),
    .core_sleep_o   (core_sleep_o),
    .retire_o       (retire)
  );

  // Observes retire events beside the core
  rv32_retire_counter u_retire_counter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .retire_i      (retire),
    .instret_o     (instret_o),
    .store_count_o (store_count_o)
  );

endmodule

//--- verif/rv32_tb_model.svh
`ifndef RV32_TB_MODEL_SVH
`define RV32_TB_MODEL_SVH

// Instruction kinds of the generated programs
localparam int K_ALU  = 0;
localparam int K_ADDI = 1;
localparam int K_LUI  = 2;
localparam int K_LW   = 3;
localparam int K_SW   = 4;
localparam int K_BEQ  = 5;

// Program fields with one entry per instruction
int          p_kind[$];
int          p_op[$];
int          p_rd[$];
int          p_rs1[$];
int          p_rs2[$];
logic [31:0] p_imm[$];
logic [31:0] prog[$];
int          prog_len;

logic [31:0] model_mem [DATA_WORDS];
obi_req_t    exp_stores[$];
logic [31:0] exp_retired;
logic [31:0] exp_store_count;
logic [31:0] gen_state;
logic [31:0] ibus_state;
logic [31:0] dbus_state;

function automatic logic [31:0] rand_word(inout logic [31:0] state);
  state = state * 32'd1664525 + 32'd1013904223;
  return state;
endfunction

// Upper LCG bits since the low ones repeat quickly
function automatic int unsigned rand_below(inout logic [31:0] state, input int unsigned n);
  logic [31:0] w;
  w = rand_word(state);
  return w[31:8] % n;
endfunction

function automatic void flag_failure(input string msg);
  $display("%s", msg);
  errors++;
endfunction

function automatic string format_req(input obi_req_t r);
  return $sformatf("addr=0x%08h wdata=0x%08h we=0x%0h be=0x%0h",
                   r.addr, r.wdata, r.we, r.be);
endfunction

task automatic check_count(input logic [31:0] act, input logic [31:0] exp, input string name);
  if (act !== exp) begin
    $display("ERROR %s exp=0x%08h got=0x%08h", name, exp, act);
    errors++;
  end
endtask

task automatic check_store(input obi_req_t exp, input obi_req_t act, input string name);
  if (act !== exp) begin
    $display("ERROR %s exp %s got %s", name, format_req(exp), format_req(act));
    errors++;
  end
endtask

task automatic check_halt();
  check_count({31'd0, core_sleep_o}, 32'd1, "core_sleep_o");
  if (instr_req_o !== 1'b0 || data_req_o !== 1'b0) begin
    flag_failure("A bus request is still active after the core halted");
  end
endtask

// Encodings straight from the RV32I base formats
function automatic logic [31:0] encode(input int kind, input int op, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [4:0] rs2,
                                       input logic [31:0] imm);
  logic [2:0] f3;
  f3 = (op == 2) ? 3'b111 : (op == 3) ? 3'b110 : (op == 4) ? 3'b100 : 3'b000;
  case (kind)
    K_ALU:   return {((op == 1) ? 7'b0100000 : 7'b0000000), rs2, rs1, f3, rd, 7'b0110011};
    K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    K_LUI:   return {imm[31:12], rd, 7'b0110111};
    K_LW:    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    K_SW:    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    default: return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endcase
endfunction

task automatic gen_program();
  int          kind;
  int          rs1;
  int          span;
  logic [31:0] w;
  logic [31:0] imm;
  p_kind.delete();
  p_op.delete();
  p_rd.delete();
  p_rs1.delete();
  p_rs2.delete();
  p_imm.delete();
  prog.delete();
  prog_len = 24 + rand_below(gen_state, 25);
  for (int i = 0; i < prog_len; i++) begin
    kind = rand_below(gen_state, 6);
    rs1  = rand_below(gen_state, 8);
    w    = rand_word(gen_state);
    imm  = {{20{w[11]}}, w[11:0]};
    if (kind == K_LUI) imm = {w[31:12], 12'h000};
    if (kind == K_LW || kind == K_SW) begin
      // Absolute word address off x0
      rs1 = 0;
      imm = DATA_BASE + 4 * rand_below(gen_state, DATA_WORDS);
    end
    if (kind == K_BEQ) begin
      span = (prog_len - i > 3) ? 3 : prog_len - i;
      imm  = 4 * (1 + rand_below(gen_state, span));
    end
    p_kind.push_back(kind);
    p_op.push_back(rand_below(gen_state, 5));
    p_rd.push_back(rand_below(gen_state, 8));
    p_rs1.push_back(rs1);
    // Equal sources now and then so BEQ gets taken
    p_rs2.push_back((rand_below(gen_state, 4) == 0) ? rs1 : rand_below(gen_state, 8));
    p_imm.push_back(imm);
    prog.push_back(encode(kind, p_op[i], 5'(p_rd[i]), 5'(rs1), 5'(p_rs2[i]), imm));
  end
  prog.push_back(32'h0000_0000);
endtask

function automatic logic [31:0] model_alu(input int op, input logic [31:0] a,
                                          input logic [31:0] b);
  case (op)
    0:       return a + b;
    1:       return a - b;
    2:       return a & b;
    3:       return a | b;
    default: return a ^ b;
  endcase
endfunction

task automatic run_model();
  logic [31:0] x [0:7];
  logic [31:0] addr;
  logic        taken;
  obi_req_t    st;
  int          i;
  for (int r = 0; r < 8; r++) x[r] = '0;
  i = 0;
  exp_retired = '0;
  exp_store_count = '0;
  exp_stores.delete();
  // Runs until the trailing zero word
  while (i < prog_len) begin
    taken = 1'b0;
    addr  = x[p_rs1[i]] + p_imm[i];
    exp_retired++;
    case (p_kind[i])
      K_ALU:  x[p_rd[i]] = model_alu(p_op[i], x[p_rs1[i]], x[p_rs2[i]]);
      K_ADDI: x[p_rd[i]] = addr;
      K_LUI:  x[p_rd[i]] = p_imm[i];
      K_LW:   x[p_rd[i]] = model_mem[(addr - DATA_BASE) >> 2];
      K_SW: begin
        model_mem[(addr - DATA_BASE) >> 2] = x[p_rs2[i]];
        st = '{req: 1'b1, addr: addr, we: 1'b1, be: 4'hf, wdata: x[p_rs2[i]]};
        exp_stores.push_back(st);
        exp_store_count++;
      end
      default: taken = (x[p_rs1[i]] == x[p_rs2[i]]);
    endcase
    x[0] = '0;
    i = taken ? i + int'(p_imm[i] >> 2) : i + 1;
  end
endtask

`endif

//--- verif/rv32_tb.sv
`timescale 1ns/1ps

module rv32_tb;
  import rv32_pkg::*;

  localparam int          N_TESTS    = 8;
  localparam int          MAX_INSTR  = 200;
  localparam int          DATA_WORDS = 64;
  localparam logic [31:0] BOOT_ADDR  = 32'h0000_1000;
  localparam logic [31:0] DATA_BASE  = 32'h0000_0400;
  localparam logic [31:0] SEED       = 32'hf0efcb94;

  logic        clk_i;
  logic        rst_n_i;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_addr_o;
  logic [31:0] instr_rdata_i;
  logic        instr_err_i;
  logic        data_req_o;
  logic        data_gnt_i;
  logic        data_rvalid_i;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic [31:0] data_rdata_i;
  logic        data_err_i;
  logic        core_sleep_o;
  logic [31:0] instret_o;
  logic [31:0] store_count_o;

  logic [31:0] dmem [DATA_WORDS];
  int          errors;
  int          pass_count;
  int          fail_count;

  `include "rv32_tb_model.svh"

  rv32_core_wrapper u_rv32_core_wrapper (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    #(N_TESTS * MAX_INSTR * 10 * 4);
    $display("Watchdog expired before all programs halted");
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    int idx;
    idx = (addr - BOOT_ADDR) >> 2;
    if (addr[1:0] != 2'b00 || addr < BOOT_ADDR || idx >= prog.size()) begin
      flag_failure($sformatf("Fetch at 0x%08h lies outside the program", addr));
      return 32'h0000_0000;
    end
    return prog[idx];
  endfunction

  function automatic int data_index(input logic [31:0] addr);
    if (addr[1:0] != 2'b00 || addr < DATA_BASE || addr >= DATA_BASE + 4 * DATA_WORDS) begin
      flag_failure($sformatf("Data access at 0x%08h lies outside the data memory", addr));
      return 0;
    end
    return (addr - DATA_BASE) >> 2;
  endfunction

  // Instruction memory with 0..3 cycles to grant and 1..3 to respond
  initial begin : instr_bus
    logic [31:0] addr;
    forever begin
      @(posedge clk_i);
      #1;
      if (instr_req_o === 1'b1) begin
        addr = instr_addr_o;
        if (core_sleep_o === 1'b1) flag_failure("Instruction request after halt");
        repeat (rand_below(ibus_state, 4)) begin
          @(posedge clk_i);
          #1;
          check_count({31'd0, instr_req_o}, 32'd1, "instr_req_o");
          check_count(instr_addr_o, addr, "instr_addr_o");
        end
        instr_gnt_i = 1'b1;
        @(posedge clk_i);
        #1;
        instr_gnt_i = 1'b0;
        repeat (rand_below(ibus_state, 3)) begin
          @(posedge clk_i);
          #1;
        end
        instr_rdata_i  = fetch_word(addr);
        instr_rvalid_i = 1'b1;
        @(posedge clk_i);
        #1;
        instr_rvalid_i = 1'b0;
      end
    end
  end

  // Data memory that checks each store as it is granted
  initial begin : data_bus
    obi_req_t held;
    obi_req_t cur;
    int       idx;
    forever begin
      @(posedge clk_i);
      #1;
      if (data_req_o === 1'b1) begin
        held = '{req: 1'b1, addr: data_addr_o, we: data_we_o, be: data_be_o,
                 wdata: data_wdata_o};
        if (core_sleep_o === 1'b1) flag_failure("Data request after halt");
        repeat (rand_below(dbus_state, 4)) begin
          @(posedge clk_i);
          #1;
          cur = '{req: data_req_o, addr: data_addr_o, we: data_we_o, be: data_be_o,
                  wdata: data_wdata_o};
          check_store(held, cur, "data_req_o");
        end
        data_gnt_i = 1'b1;
        idx = data_index(held.addr);
        if (held.we) begin
          if (exp_stores.size() == 0) begin
            flag_failure($sformatf("Store to 0x%08h that the model never made", held.addr));
          end else begin
            check_store(exp_stores.pop_front(), held, "data_req_o");
          end
          dmem[idx] = held.wdata;
        end
        @(posedge clk_i);
        #1;
        data_gnt_i = 1'b0;
        repeat (rand_below(dbus_state, 3)) begin
          @(posedge clk_i);
          #1;
        end
        data_rdata_i  = held.we ? 32'h0000_0000 : dmem[idx];
        data_rvalid_i = 1'b1;
        @(posedge clk_i);
        #1;
        data_rvalid_i = 1'b0;
      end
    end
  end

  task automatic run_test(input int t);
    int err_before;
    err_before = errors;
    fetch_enable_i = 1'b0;
    gen_program();
    for (int i = 0; i < DATA_WORDS; i++) begin
      dmem[i]      = (DATA_BASE + 4 * i) * 32'h9e37_79b1 + t;
      model_mem[i] = dmem[i];
    end
    run_model();
    rst_n_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    // Core must stay idle until fetch is enabled
    repeat (10) begin
      @(posedge clk_i);
      #1;
      if (instr_req_o !== 1'b0 || data_req_o !== 1'b0 || core_sleep_o !== 1'b0) begin
        flag_failure("Core left idle before fetch enable");
      end
    end
    fetch_enable_i = 1'b1;
    do begin
      @(posedge clk_i);
      #1;
    end while (instr_req_o !== 1'b1);
    check_count(instr_addr_o, BOOT_ADDR, "instr_addr_o");
    do begin
      @(posedge clk_i);
      #1;
    end while (core_sleep_o !== 1'b1);
    repeat (10) @(posedge clk_i);
    #1;
    check_halt();
    check_count(instret_o, exp_retired, "instret_o");
    check_count(store_count_o, exp_store_count, "store_count_o");
    if (exp_stores.size() != 0) begin
      flag_failure($sformatf("%0d expected stores never reached the data bus",
                             exp_stores.size()));
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      check_count(dmem[i], model_mem[i], $sformatf("dmem[%0d]", i));
    end
    if (errors == err_before) pass_count++;
    else fail_count++;
    $display("test %0d: %0d instructions, %0d retired, %0d stores, %s", t, prog_len,
             exp_retired, exp_store_count, (errors == err_before) ? "passed" : "failed");
  endtask

  initial begin
    rst_n_i        = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    data_err_i     = 1'b0;
    errors         = 0;
    pass_count     = 0;
    fail_count     = 0;
    gen_state      = SEED;
    ibus_state     = SEED + 32'd1;
    dbus_state     = SEED + 32'd2;
    for (int t = 0; t < N_TESTS; t++) run_test(t);
    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+verif
design/rv32_pkg.sv
design/rv32_decoder.sv
design/rv32_alu.sv
design/rv32_register_file.sv
design/rv32_load_store_unit.sv
design/rv32_core.sv
design/rv32_retire_counter.sv
design/rv32_core_wrapper.sv
verif/rv32_tb.sv
